/* all.f */
hdl/div_pkg.sv
hdl/div_lane.sv
hdl/div_dispatch.sv
hdl/div_collect.sv
hdl/div_array_top.sv
verification/tb_clock.sv
verification/div_array_properties.sv
verification/div_array_tb.sv

/* hdl/div_array_top.sv */
// multi-lane divider: dispatcher, NUM_LANES restoring lanes, collector
// responses leave in request order; up to NUM_LANES divisions in flight

module div_array_top #(
  parameter int NUM_LANES = 4
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_val,
  output logic               in_rdy,
  input  div_pkg::div_req_t  in_req,
  output logic               out_val,
  input  logic               out_rdy,
  output div_pkg::div_resp_t out_resp
);

  // ------------------------------
  // per-lane handshake wires
  // ------------------------------
  logic [NUM_LANES-1:0] lane_req_val;
  logic [NUM_LANES-1:0] lane_req_rdy;
  logic [NUM_LANES-1:0] lane_resp_val;
  logic [NUM_LANES-1:0] lane_resp_rdy;
  div_pkg::div_resp_t   lane_resp [NUM_LANES];

  div_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .clk          (clk),
    .reset        (reset),
    .in_val       (in_val),
    .in_rdy       (in_rdy),
    .lane_req_val (lane_req_val),
    .lane_req_rdy (lane_req_rdy)
  );

  // request payload goes to every lane, only the strobed one loads it
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    div_lane u_lane (
      .clk      (clk),
      .reset    (reset),
      .req_val  (lane_req_val[i]),
      .req_rdy  (lane_req_rdy[i]),
      .req      (in_req),
      .resp_val (lane_resp_val[i]),
      .resp_rdy (lane_resp_rdy[i]),
      .resp     (lane_resp[i])
    );
  end

  div_collect #(
    .NUM_LANES (NUM_LANES)
  ) u_collect (
    .clk           (clk),
    .reset         (reset),
    .lane_resp_val (lane_resp_val),
    .lane_resp     (lane_resp),
    .lane_resp_rdy (lane_resp_rdy),
    .out_val       (out_val),
    .out_rdy       (out_rdy),
    .out_resp      (out_resp)
  );

endmodule

/* hdl/div_collect.sv */
// in-order drain of lane responses, same round-robin order as issue
// output holds while the pointed lane sits in done and out_rdy is low

module div_collect #(
  parameter int NUM_LANES = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [NUM_LANES-1:0] lane_resp_val,
  input  div_pkg::div_resp_t   lane_resp [NUM_LANES],
  output logic [NUM_LANES-1:0] lane_resp_rdy,
  output logic                 out_val,
  input  logic                 out_rdy,
  output div_pkg::div_resp_t   out_resp
);

  localparam int ptr_w = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // ------------------------------
  // drain pointer
  // ------------------------------
  logic [ptr_w-1:0] drain_ptr;
  logic             drain_fire;
  logic             ptr_at_last;

  // output mux from the lane whose turn it is
  assign out_val     = lane_resp_val[drain_ptr];
  assign out_resp    = lane_resp[drain_ptr];
  assign drain_fire  = out_val && out_rdy;
  assign ptr_at_last = drain_ptr == ptr_w'(NUM_LANES - 1);

  // only the pointed lane may leave done
  always_comb begin
    lane_resp_rdy            = '0;
    lane_resp_rdy[drain_ptr] = out_rdy;
  end

  // pointer moves only on a transfer, so order tracks issue order
  always_ff @(posedge clk) begin
    if (reset) begin
      drain_ptr <= '0;
    end else if (drain_fire) begin
      if (ptr_at_last) begin
        drain_ptr <= '0;
      end else begin
        drain_ptr <= drain_ptr + 1'b1;
      end
    end
  end

endmodule

/* hdl/div_dispatch.sv */
// round-robin issue of requests to the lanes, strictly in lane order
// stalls on the pointed lane even if another lane is idle

module div_dispatch #(
  parameter int NUM_LANES = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_val,
  output logic                 in_rdy,
  output logic [NUM_LANES-1:0] lane_req_val,
  input  logic [NUM_LANES-1:0] lane_req_rdy
);

  // pointer width, at least one bit for a single lane
  localparam int ptr_w = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // ------------------------------
  // issue pointer
  // ------------------------------
  logic [ptr_w-1:0] issue_ptr;
  logic             issue_fire;
  logic             ptr_at_last;

  // ready comes only from the lane next in line
  assign in_rdy      = lane_req_rdy[issue_ptr];
  assign issue_fire  = in_val && in_rdy;
  assign ptr_at_last = issue_ptr == ptr_w'(NUM_LANES - 1);

  // valid strobe steered to one lane, all others see low
  always_comb begin
    lane_req_val            = '0;
    lane_req_val[issue_ptr] = in_val;
  end

  // advance and wrap on every accepted request
  always_ff @(posedge clk) begin
    if (reset) begin
      issue_ptr <= '0;
    end else if (issue_fire) begin
      if (ptr_at_last) begin
        issue_ptr <= '0;
      end else begin
        issue_ptr <= issue_ptr + 1'b1;
      end
    end
  end

endmodule

/* hdl/div_lane.sv */
// iterative restoring divider, one quotient bit per cycle for 32 cycles
// accepts only in idle; holds its response in done until resp_rdy
// divide by zero returns all ones and the dividend as remainder

module div_lane (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_val,
  output logic               req_rdy,
  input  div_pkg::div_req_t  req,
  output logic               resp_val,
  input  logic               resp_rdy,
  output div_pkg::div_resp_t resp
);

  localparam int cnt_w = $clog2(div_pkg::div_iters);

  // ------------------------------
  // control state
  // ------------------------------
  div_pkg::lane_state_e state;
  logic [cnt_w-1:0]     iter_cnt;
  logic                 accept;
  logic                 send;
  logic                 last_iter;

  // ------------------------------
  // datapath
  // ------------------------------
  // partial remainder in [64:32], quotient bits shift in at [0]
  logic [64:0]        rq_reg;
  logic [64:0]        shifted;
  logic [64:0]        trial;
  logic [64:0]        rq_next;
  div_pkg::div_word_t b_mag;
  logic               a_neg;
  logic               b_neg;

  // operand conditioning at accept time
  logic               a_neg_in;
  logic               b_neg_in;
  div_pkg::div_word_t a_mag_in;
  div_pkg::div_word_t b_mag_in;

  // result forming
  div_pkg::div_word_t quot_mag;
  div_pkg::div_word_t rem_mag;
  div_pkg::div_word_t quot_signed;
  div_pkg::div_word_t rem_signed;

  assign accept    = req_val && req_rdy;
  assign send      = resp_val && resp_rdy;
  assign last_iter = iter_cnt == cnt_w'(div_pkg::div_iters - 1);

  // sign bits only count in signed mode
  assign a_neg_in = (req.fn == div_pkg::div_signed) && req.a[31];
  assign b_neg_in = (req.fn == div_pkg::div_signed) && req.b[31];
  // most negative value maps onto 2^31, which is still a correct magnitude
  assign a_mag_in = a_neg_in ? (~req.a + 32'd1) : req.a;
  assign b_mag_in = b_neg_in ? (~req.b + 32'd1) : req.b;

  // shift, trial subtract, keep or restore
  assign shifted = rq_reg << 1;
  assign trial   = shifted - {1'b0, b_mag, 32'b0};
  // borrow out of bit 64 means the divisor did not fit
  assign rq_next = trial[64] ? shifted : {trial[64:1], 1'b1};

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= div_pkg::idle;
      iter_cnt <= '0;
    end else begin
      case (state)
        div_pkg::idle: begin
          if (accept) begin
            state    <= div_pkg::calc;
            iter_cnt <= '0;
          end
        end
        div_pkg::calc: begin
          // exactly div_iters cycles here, counter wraps back to zero
          if (last_iter) begin
            state <= div_pkg::done;
          end
          iter_cnt <= iter_cnt + 1'b1;
        end
        div_pkg::done: begin
          if (send) begin
            state <= div_pkg::idle;
          end
        end
        default: state <= div_pkg::idle;
      endcase
    end
  end

  // payload registers, loaded on accept and stepped during calc
  always_ff @(posedge clk) begin
    if (accept) begin
      rq_reg <= {33'b0, a_mag_in};
      b_mag  <= b_mag_in;
      a_neg  <= a_neg_in;
      b_neg  <= b_neg_in;
    end else if (state == div_pkg::calc) begin
      rq_reg <= rq_next;
    end
  end

  assign req_rdy  = state == div_pkg::idle;
  assign resp_val = state == div_pkg::done;

  assign quot_mag = rq_reg[31:0];
  assign rem_mag  = rq_reg[63:32];

  // quotient negative when exactly one operand is negative
  assign quot_signed = (a_neg ^ b_neg) ? (~quot_mag + 32'd1) : quot_mag;
  // remainder follows the dividend sign
  assign rem_signed  = a_neg ? (~rem_mag + 32'd1) : rem_mag;

  // with a zero divisor every step succeeds, so rem_mag is the dividend magnitude
  // and rem_signed already equals the dividend; only the quotient needs forcing
  assign resp.quot = (b_mag == '0) ? '1 : quot_signed;
  assign resp.rem  = rem_signed;

endmodule

/* hdl/div_pkg.sv */
// shared types for the multi-lane integer divider
// operand width is fixed at 32 bits by the request format

package div_pkg;

  // ------------------------------
  // data words
  // ------------------------------

  // operand, quotient or remainder
  typedef logic [31:0] div_word_t;

  // division function carried with each request
  typedef enum logic {
    div_unsigned = 1'b0,
    div_signed   = 1'b1
  } div_fn_e;

  // request message, 65 bits: fn in the top bit, then dividend, then divisor
  typedef struct packed {
    div_fn_e   fn;
    div_word_t a;
    div_word_t b;
  } div_req_t;

  // response message, 64 bits: remainder high, quotient low
  typedef struct packed {
    div_word_t rem;
    div_word_t quot;
  } div_resp_t;

  // lane control states
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } lane_state_e;

  // one quotient bit per calc cycle
  localparam int div_iters = 32;

endpackage

/* verification/div_array_properties.sv */
// protocol checks for div_array_top, bound into every instance
// outstanding count is only meaningful once reset has been applied

module div_array_properties #(
  parameter int NUM_LANES = 4
) (
  input logic               clk,
  input logic               reset,
  input logic               in_val,
  input logic               in_rdy,
  input logic               out_val,
  input logic               out_rdy,
  input div_pkg::div_resp_t out_resp
);

  // requests accepted but not yet returned
  int outstanding;
  // failed checks so far, polled by the testbench
  int error_count = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(in_val && in_rdy) - int'(out_val && out_rdy);
    end
  end

  // ------------------------------
  // assertions
  // ------------------------------

  // output quiet in the cycle after reset
  out_quiet_after_reset: assert property (@(posedge clk) reset |=> !out_val)
    else begin
      error_count++;
      $error("out_val high in the cycle after reset");
    end

  // held response must not change or drop before the transfer
  out_held_stable: assert property (@(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val && $stable(out_resp))
    else begin
      error_count++;
      $error("response changed or dropped while out_rdy was low");
    end

  // every lane busy, so the pointed lane cannot take a request
  in_stall_when_full: assert property (@(posedge clk) disable iff (reset)
    outstanding == NUM_LANES |-> !in_rdy)
    else begin
      error_count++;
      $error("in_rdy high with all lanes occupied");
    end

endmodule

bind div_array_top div_array_properties #(
  .NUM_LANES (NUM_LANES)
) u_props (
  .clk      (clk),
  .reset    (reset),
  .in_val   (in_val),
  .in_rdy   (in_rdy),
  .out_val  (out_val),
  .out_rdy  (out_rdy),
  .out_resp (out_resp)
);

/* verification/div_array_tb.sv */
// testbench for div_array_top with four lanes, checks results in request order
// reference model is native truncating division plus the zero and overflow rules

module div_array_tb;

  localparam int num_lanes      = 4;
  localparam int timeout_cycles = 2000;

  logic               clk;
  logic               reset;
  logic               in_val;
  logic               in_rdy;
  div_pkg::div_req_t  in_req;
  logic               out_val;
  logic               out_rdy;
  div_pkg::div_resp_t out_resp;

  // random output stalls when set
  logic               backpressure;
  string              test_name;
  div_pkg::div_resp_t expected_q [$];

  tb_clock clock0 (.clk(clk));

  div_array_top #(
    .NUM_LANES (num_lanes)
  ) dut0 (
    .clk      (clk),
    .reset    (reset),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .in_req   (in_req),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .out_resp (out_resp)
  );

  // ------------------------------
  // reference model and helpers
  // ------------------------------
  function automatic div_pkg::div_resp_t model_div(input div_pkg::div_req_t req);
    div_pkg::div_resp_t r;
    if (req.b == '0) begin
      r.quot = '1;
      r.rem  = req.a;
    end else if (req.fn == div_pkg::div_unsigned) begin
      r.quot = req.a / req.b;
      r.rem  = req.a % req.b;
    end else if (req.a == 32'h8000_0000 && req.b == '1) begin
      // signed overflow wraps to the most negative value
      r.quot = 32'h8000_0000;
      r.rem  = '0;
    end else begin
      r.quot = $signed(req.a) / $signed(req.b);
      r.rem  = $signed(req.a) % $signed(req.b);
    end
    return r;
  endfunction

  function automatic div_pkg::div_req_t make_req(input div_pkg::div_fn_e fn,
                                                 input div_pkg::div_word_t a,
                                                 input div_pkg::div_word_t b);
    div_pkg::div_req_t r;
    r.fn = fn;
    r.a  = a;
    r.b  = b;
    return r;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  // hold in_val until the pointed lane takes the request
  task automatic send_req(input div_pkg::div_req_t req);
    int waited;
    waited = 0;
    in_val <= 1'b1;
    in_req <= req;
    @(posedge clk);
    while (!in_rdy) begin
      waited++;
      if (waited > timeout_cycles) begin
        fail_now("request was not accepted before the timeout");
      end
      @(posedge clk);
    end
    in_val <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0) begin
      waited++;
      if (waited > timeout_cycles) begin
        fail_now("responses did not drain before the timeout");
      end
      @(posedge clk);
    end
  endtask

  // output ready, random only while back-pressure is on
  always @(posedge clk) begin
    if (backpressure) begin
      out_rdy <= $urandom_range(0, 1) == 1;
    end else begin
      out_rdy <= 1'b1;
    end
  end

  // ------------------------------
  // transfer monitor
  // ------------------------------
  always @(posedge clk) begin
    if (dut0.u_props.error_count != 0) begin
      fail_now("a protocol assertion failed");
    end
    // check the output before pushing, a queue head never shares an edge with its push
    if (!reset && out_val && out_rdy) begin
      if (expected_q.size() == 0) begin
        fail_now("response arrived with no request outstanding");
      end
      check_resp: assert (out_resp == expected_q[0])
        else fail_now($sformatf("Mismatch in %s: expected %h, actual %h",
                                test_name, expected_q[0], out_resp));
      void'(expected_q.pop_front());
    end
    if (!reset && in_val && in_rdy) begin
      expected_q.push_back(model_div(in_req));
    end
  end

  initial begin
    div_pkg::div_word_t mags [4] = '{32'd1, 32'd7, 32'd12345, 32'h7fff_fffd};
    div_pkg::div_word_t a;
    div_pkg::div_word_t b;
    int cycles;
    void'($urandom(28));
    backpressure = 1'b0;
    in_val       = 1'b0;
    in_req       = '0;
    out_rdy      = 1'b1;
    reset        = 1'b1;
    test_name    = "reset";
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    // single request into an idle array, fixed latency
    test_name = "latency";
    send_req(make_req(div_pkg::div_unsigned, 32'd1000, 32'd7));
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > timeout_cycles) begin
        fail_now("out_val did not rise before the timeout");
      end
    end while (!out_val);
    latency_check: assert (cycles == 33)
      else fail_now($sformatf("Mismatch in %s: expected %0d, actual %0d",
                              test_name, 33, cycles));
    wait_drain();

    // back to back unsigned, divisor magnitude spread by a random shift
    test_name = "unsigned_random";
    for (int i = 0; i < 40; i++) begin
      a = $urandom;
      b = $urandom >> $urandom_range(0, 31);
      send_req(make_req(div_pkg::div_unsigned, a, b));
    end
    wait_drain();

    // all four sign combinations over small and large magnitudes
    test_name = "signed_signs";
    foreach (mags[i]) begin
      foreach (mags[j]) begin
        for (int s = 0; s < 4; s++) begin
          a = s[0] ? -mags[i] : mags[i];
          b = s[1] ? -mags[j] : mags[j];
          send_req(make_req(div_pkg::div_signed, a, b));
        end
      end
    end
    wait_drain();

    test_name = "divide_by_zero";
    send_req(make_req(div_pkg::div_unsigned, $urandom, 32'd0));
    send_req(make_req(div_pkg::div_unsigned, 32'd0, 32'd0));
    send_req(make_req(div_pkg::div_signed, 32'hffff_ff85, 32'd0));
    send_req(make_req(div_pkg::div_signed, 32'd4242, 32'd0));
    wait_drain();

    test_name = "signed_overflow";
    send_req(make_req(div_pkg::div_signed, 32'h8000_0000, 32'hffff_ffff));
    send_req(make_req(div_pkg::div_signed, 32'h8000_0000, 32'd1));
    wait_drain();

    // random stalls fill every lane so in_rdy must fall
    test_name = "backpressure";
    backpressure = 1'b1;
    for (int i = 0; i < 48; i++) begin
      a = $urandom;
      b = $urandom >> $urandom_range(0, 31);
      if ($urandom_range(0, 1) == 1) begin
        send_req(make_req(div_pkg::div_signed, a, b));
      end else begin
        send_req(make_req(div_pkg::div_unsigned, a, b));
      end
    end
    wait_drain();
    backpressure = 1'b0;
    repeat (4) @(posedge clk);

    if (expected_q.size() == 0 && dut0.u_props.error_count == 0) begin
      $display("** PASS **");
    end else begin
      fail_now("run ended with a protocol failure or a missing response");
    end
    $finish;
  end

endmodule

/* verification/tb_clock.sv */
// free-running testbench clock, starts low
// half period fixed by parameter, full period 40

module tb_clock #(
  parameter int half_period = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

endmodule
